// ==== bench/mipsCpuBusSva_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

module mipsCpuBusSva import isaPkg::*; (
    input wire logic  clk,
    input wire logic  rst,
    input wire logic  read,
    input wire logic  write,
    input wire logic  waitrequest,
    input wire logic  active,
    input wire word_t address,
    input wire word_t writedata
);

    int failures = 0;

    noDualStrobe: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else begin
            $error("read and write high in the same cycle");
            failures++;
        end

    // Stalled transfer keeps strobe, address and data
    holdDuringWait: assert property (@(posedge clk) disable iff (rst)
        (read || write) && waitrequest |=> $stable(read) && $stable(write)
            && $stable(address) && $stable(writedata))
        else begin
            $error("bus request changed while waitrequest was high");
            failures++;
        end

    staysHalted: assert property (@(posedge clk) disable iff (rst) !active |=> !active)
        else begin
            $error("active rose again without a reset");
            failures++;
        end

endmodule

bind mipsCpuBus mipsCpuBusSva sva0 (
    .clk(clk), .rst(rst), .read(read), .write(write), .waitrequest(waitrequest),
    .active(active), .address(address), .writedata(writedata)
);

`default_nettype wire

// ==== bench/mipsCpuBusTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module mipsCpuBusTb import isaPkg::*; ();

    localparam word_t ResetVector = 32'd256;
    localparam int NumTests = 5;
    localparam int MaxLen = 16;
    localparam int MemWords = 1024;
    localparam int TimeoutCycles = NumTests * 64 * 20;
    localparam word_t Nop = '0;
    localparam word_t Idle = 32'hBAD0_BAD0;   // Readdata outside a completing cycle

    logic clk;
    logic rst = 1'b1;
    logic waitrequest = 1'b0;
    word_t readdata = '0;
    logic active;
    logic write;
    logic read;
    word_t registerV0;
    word_t address;
    word_t writedata;

    word_t mem [MemWords];
    word_t progs [NumTests][MaxLen];
    word_t expV0 [NumTests];
    int expStores [NumTests];
    word_t expAddr [NumTests];
    word_t expData [NumTests];

    logic [31:0] lfsr = 32'd84480;
    logic busy = 1'b0;
    int stallLeft = 0;
    int storeCount = 0;
    word_t lastAddr = '0;
    word_t lastData = '0;
    int cycles = 0;

    mipsCpuBus #(.ResetVector(ResetVector)) dut0 (
        .clk(clk), .rst(rst), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .readdata(readdata)
    );

    function automatic word_t iType(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t rType(func_t fn, int rs, int rt, int rd, int sh);
        return {OpR, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t jType(opcode_t op, word_t target);
        return {op, target[27:2]};
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic stopRun(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "%s", msg);
    endtask

    task automatic checkWord(word_t got, word_t exp, string what);
        if (got !== exp) begin
            stopRun($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic checkStore(word_t gotAddr, word_t gotData, word_t wantAddr, word_t wantData);
        if (gotAddr !== wantAddr || gotData !== wantData) begin
            stopRun($sformatf("Mismatch at %0t: store %h <= %h, expected %h <= %h",
                $time, gotAddr, gotData, wantAddr, wantData));
        end
    endtask

    task automatic buildTable();
        // Immediate ops, v0 = 1234779A + 890 + 1 + 0 + 1
        progs[0] = '{iType(OpAddiu, 0, 1, -5), iType(OpLui, 0, 2, 'h1234),
            iType(OpOri, 2, 2, 'h8765), iType(OpXori, 2, 2, 'hFFFF),
            iType(OpAndi, 2, 3, 'h0FF0), iType(OpSlti, 1, 4, -4),
            iType(OpSltiu, 1, 5, 5), iType(OpSltiu, 0, 6, -1),
            iType(OpAddiu, 2, 2, -256), rType(FnAddu, 2, 3, 2, 0),
            rType(FnAddu, 2, 4, 2, 0), rType(FnAddu, 2, 5, 2, 0),
            rType(FnAddu, 2, 6, 2, 0), rType(FnJr, 0, 0, 0, 0), Nop, Nop};
        // R-type and shifts
        progs[1] = '{iType(OpAddiu, 0, 1, 'hF0), iType(OpLui, 0, 3, 'h8000),
            rType(FnSll, 0, 1, 4, 8), rType(FnSrl, 0, 3, 5, 4),
            rType(FnSra, 0, 3, 6, 4), rType(FnSubu, 0, 1, 7, 0),
            rType(FnSlt, 7, 1, 8, 0), rType(FnSltu, 7, 1, 9, 0),
            rType(FnAnd, 7, 4, 10, 0), rType(FnXor, 6, 5, 11, 0),
            rType(FnOr, 11, 10, 2, 0), rType(FnAddu, 2, 8, 2, 0),
            rType(FnAddu, 2, 9, 2, 0), rType(FnJr, 0, 0, 0, 0), Nop, Nop};
        // Store then load back
        progs[2] = '{iType(OpLui, 0, 1, 'hCAFE), iType(OpOri, 1, 1, 'hF00D),
            iType(OpAddiu, 0, 3, 'h800), iType(OpSw, 3, 1, 'h10),
            iType(OpLw, 3, 2, 'h10), rType(FnJr, 0, 0, 0, 0),
            Nop, Nop, Nop, Nop, Nop, Nop, Nop, Nop, Nop, Nop};
        // Taken and not-taken branches with delay slots
        progs[3] = '{iType(OpAddiu, 0, 1, 3), iType(OpAddiu, 0, 3, 3),
            iType(OpBeq, 1, 3, 3), iType(OpAddiu, 0, 2, 'h10),
            iType(OpAddiu, 2, 2, 'h100), iType(OpAddiu, 2, 2, 'h200),
            iType(OpBne, 1, 3, 2), iType(OpAddiu, 2, 2, 1),
            iType(OpAddiu, 2, 2, 2), iType(OpBne, 1, 0, 2),
            iType(OpAddiu, 2, 2, 4), iType(OpAddiu, 2, 2, 'h400),
            iType(OpBeq, 1, 0, 1), iType(OpAddiu, 2, 2, 8),
            rType(FnJr, 0, 0, 0, 0), Nop};
        // JAL links 0x108, J skips one word
        progs[4] = '{jType(OpJal, 32'h110), iType(OpAddiu, 0, 2, 5),
            iType(OpAddiu, 2, 2, 'h40), iType(OpAddiu, 2, 2, 'h80),
            rType(FnAddu, 2, 31, 2, 0), jType(OpJ, 32'h120),
            iType(OpAddiu, 2, 2, 'h1000), iType(OpAddiu, 2, 2, 'h2000),
            rType(FnJr, 0, 0, 0, 0), Nop, Nop, Nop, Nop, Nop, Nop, Nop};
        expV0 = '{32'h1234_802C, 32'hF000_F001, 32'hCAFE_F00D, 32'h0000_001F, 32'h0000_110D};
        expStores = '{0, 0, 1, 0, 0};
        expAddr = '{32'h0, 32'h0, 32'h810, 32'h0, 32'h0};
        expData = '{32'h0, 32'h0, 32'hCAFE_F00D, 32'h0, 32'h0};
    endtask

    task automatic loadProgram(int n);
        int base;
        base = ResetVector / 4;
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = 32'hC0DE_0000 + i;
        end
        for (int i = 0; i < MaxLen; i++) begin
            mem[base + i] = progs[n][i];
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TimeoutCycles) begin
            stopRun($sformatf("Timeout after %0d cycles without the CPU halting", cycles));
        end
        if (dut0.sva0.failures != 0) begin
            stopRun("A bus assertion failed");
        end
    end

    // Slave with random stalls of 0 to 3 cycles per transfer
    always @(posedge clk) begin
        #1;
        readdata = Idle;
        if (read || write) begin
            if (rst) begin
                stopRun("Bus strobe high during reset");
            end
            if (!active) begin
                stopRun("Bus access after the CPU halted");
            end
            if (address >= MemWords * 4 || address[1:0] != 2'b00 || address == '0) begin
                stopRun($sformatf("Bus access to invalid address %h", address));
            end
            if (!busy) begin
                busy = 1'b1;
                stallLeft = 0;
                for (int k = 0; k < 2; k++) begin
                    lfsr = lfsrStep(lfsr);
                    stallLeft = stallLeft * 2 + lfsr[0];
                end
            end
            if (stallLeft > 0) begin
                waitrequest = 1'b1;
                stallLeft--;
            end else begin
                waitrequest = 1'b0;   // Transfer completes this cycle
                busy = 1'b0;
                if (write) begin
                    mem[address[11:2]] = writedata;
                    storeCount++;
                    lastAddr = address;
                    lastData = writedata;
                end else begin
                    readdata = mem[address[11:2]];
                end
            end
        end else begin
            waitrequest = 1'b0;
        end
    end

    initial begin
        buildTable();
        for (int n = 0; n < NumTests; n++) begin
            @(posedge clk);
            #1;
            rst = 1'b1;
            loadProgram(n);
            storeCount = 0;
            repeat (10) @(posedge clk);
            #1;
            rst = 1'b0;
            do begin
                @(posedge clk);
                #1;
            end while (active);
            repeat (8) @(posedge clk);   // Bus must stay quiet after halt
            #1;
            if (active) begin
                stopRun($sformatf("Test %0d: active rose again after the halt", n));
            end
            checkWord(registerV0, expV0[n], $sformatf("test %0d v0", n));
            checkWord(word_t'(storeCount), word_t'(expStores[n]),
                $sformatf("test %0d store count", n));
            if (expStores[n] > 0) begin
                checkStore(lastAddr, lastData, expAddr[n], expData[n]);
            end
        end
        if (dut0.sva0.failures != 0) begin
            stopRun("A bus assertion failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu import isaPkg::*, ctrlPkg::*; (
    input  wire logic       clk,
    input  wire logic       latchOperands,
    input  wire aluOp_t     op,
    input  wire word_t      opA,
    input  wire word_t      opB,
    input  wire logic [4:0] shamt,
    output word_t           result,
    output logic            zero
);

    word_t a;
    word_t b;

    // Operands stay put until the next instruction
    always_ff @(posedge clk) begin
        if (latchOperands) begin
            a <= opA;
            b <= opB;
        end
    end

    always_comb begin
        case (op)
            And: result = a & b;
            Or: result = a | b;
            Add: result = a + b;
            Sub: result = a - b;
            Slt: result = word_t'($signed(a) < $signed(b));
            Sltu: result = word_t'(a < b);
            Xor: result = a ^ b;
            Sll: result = b << shamt;   // Shifts act on rt
            Srl: result = b >> shamt;
            Sra: result = word_t'($signed(b) >>> shamt);
            Lui: result = {b[15:0], 16'b0};
            PassA: result = a;
            default: result = a + b;
        endcase
    end

    assign zero = result == '0;

endmodule

`default_nettype wire

// ==== hw/cpuControl.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpuControl import ctrlPkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic waitrequest,
    input  wire logic isLoad,
    input  wire logic isStore,
    input  wire logic pcIsZero,
    output cpuState_t state,
    output logic      read,
    output logic      write,
    output logic      active,
    output logic      latchInstr,
    output logic      latchOperands,
    output logic      regWrite,
    output logic      pcAdvance,
    input  wire logic writesReg
);

    logic started;    // Bus idle in first cycle out of reset
    logic fetchReq;
    logic memAccess;

    assign memAccess = isLoad || isStore;
    assign fetchReq = state == Fetch && started && !pcIsZero;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Fetch;
            started <= 1'b0;
            active <= 1'b1;
        end else begin
            started <= 1'b1;
            case (state)
                Fetch: begin
                    if (pcIsZero) begin
                        state <= Halted;   // Jump to zero ends the program
                    end else if (fetchReq && !waitrequest) begin
                        state <= Decode;
                    end
                end
                Decode: state <= Exec;
                Exec: state <= Mem;
                Mem: begin
                    if (!memAccess || !waitrequest) begin
                        state <= WriteBack;
                    end
                end
                WriteBack: state <= Fetch;
                Halted: active <= 1'b0;
                default: state <= Halted;
            endcase
        end
    end

    // Strobes hold until the slave drops waitrequest
    assign read = fetchReq || (state == Mem && isLoad);
    assign write = state == Mem && isStore;

    assign latchInstr = fetchReq && !waitrequest;
    assign latchOperands = state == Decode;
    assign regWrite = state == WriteBack && writesReg;
    assign pcAdvance = state == WriteBack;

endmodule

`default_nettype wire

// ==== hw/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        Fetch     = 3'd0,
        Decode    = 3'd1,
        Exec      = 3'd2,
        Mem       = 3'd3,
        WriteBack = 3'd4,
        Halted    = 3'd7
    } cpuState_t;

    typedef enum logic [3:0] {
        And   = 4'd0,
        Or    = 4'd1,
        Add   = 4'd2,
        Sub   = 4'd3,
        Slt   = 4'd4,
        Sltu  = 4'd5,
        Xor   = 4'd6,
        Sll   = 4'd7,
        Srl   = 4'd8,
        Sra   = 4'd9,
        Lui   = 4'd10,
        PassA = 4'd11   // Jump register target
    } aluOp_t;

    // Write-back data source
    typedef enum logic [1:0] {
        AluResult = 2'd0,
        MemData   = 2'd1,
        LinkAddr  = 2'd2
    } wbSel_t;

endpackage

`default_nettype wire

// ==== hw/instrDecode.sv ====
`default_nettype none
`timescale 1ns/1ps

module instrDecode import isaPkg::*, ctrlPkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  latchInstr,
    input  wire word_t readdata,
    output aluOp_t     aluOp,
    output logic       useImm,
    output logic       zeroExtImm,
    output logic       isLoad,
    output logic       isStore,
    output logic       isBranchEq,
    output logic       isBranchNe,
    output logic       isJump,
    output logic       isJumpReg,
    output logic       writesReg,
    output wbSel_t     wbSel,
    output regAddr_t   rs,
    output regAddr_t   rt,
    output regAddr_t   dest,
    output logic [4:0] shamt,
    output word_t      imm,
    output logic [25:0] jumpIndex
);

    word_t instr;
    opcode_t opcode;
    func_t func;
    logic known;

    always_ff @(posedge clk) begin
        if (rst) begin
            instr <= '0;   // Decodes as a NOP
        end else if (latchInstr) begin
            instr <= readdata;
        end
    end

    assign opcode = opcode_t'(instr[31:26]);
    assign func = func_t'(instr[5:0]);
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign shamt = instr[10:6];
    assign jumpIndex = instr[25:0];

    assign zeroExtImm = opcode inside {OpAndi, OpOri, OpXori};
    assign imm = zeroExtImm ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign useImm = !(opcode inside {OpR, OpBeq, OpBne});

    assign isLoad = opcode == OpLw;
    assign isStore = opcode == OpSw;
    assign isBranchEq = opcode == OpBeq;
    assign isBranchNe = opcode == OpBne;
    assign isJump = opcode inside {OpJ, OpJal};
    assign isJumpReg = opcode == OpR && func == FnJr;

    assign dest = (opcode == OpR) ? instr[15:11] : (opcode == OpJal) ? LinkReg : rt;
    assign wbSel = isLoad ? MemData : (opcode == OpJal) ? LinkAddr : AluResult;

    always_comb begin
        aluOp = Add;
        known = 1'b1;
        case (opcode)
            OpR: begin
                case (func)
                    FnAddu: aluOp = Add;
                    FnSubu: aluOp = Sub;
                    FnAnd: aluOp = And;
                    FnOr: aluOp = Or;
                    FnXor: aluOp = Xor;
                    FnSlt: aluOp = Slt;
                    FnSltu: aluOp = Sltu;
                    FnSll: aluOp = Sll;
                    FnSrl: aluOp = Srl;
                    FnSra: aluOp = Sra;
                    FnJr: aluOp = PassA;
                    default: known = 1'b0;
                endcase
            end
            OpAddiu, OpLw, OpSw: aluOp = Add;   // Address is rs + offset
            OpAndi: aluOp = And;
            OpOri: aluOp = Or;
            OpXori: aluOp = Xor;
            OpSlti: aluOp = Slt;
            OpSltiu: aluOp = Sltu;
            OpLui: aluOp = Lui;
            OpBeq, OpBne: aluOp = Sub;
            OpJ, OpJal: aluOp = PassA;
            default: known = 1'b0;
        endcase
    end

    // Unknown encodings retire as NOPs
    assign writesReg = known && dest != '0
        && !(isStore || isBranchEq || isBranchNe || opcode == OpJ || isJumpReg);

endmodule

`default_nettype wire

// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int WordWidth = 32;
    localparam int RegAddrWidth = 5;
    localparam int NumRegs = 32;

    typedef logic [WordWidth-1:0] word_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;

    // Kept MIPS-I primary opcodes
    typedef enum logic [5:0] {
        OpR     = 6'b000000,   // Function field selects
        OpJ     = 6'b000010,
        OpJal   = 6'b000011,
        OpBeq   = 6'b000100,
        OpBne   = 6'b000101,
        OpAddiu = 6'b001001,
        OpSlti  = 6'b001010,
        OpSltiu = 6'b001011,
        OpAndi  = 6'b001100,
        OpOri   = 6'b001101,
        OpXori  = 6'b001110,
        OpLui   = 6'b001111,
        OpLw    = 6'b100011,
        OpSw    = 6'b101011
    } opcode_t;

    typedef enum logic [5:0] {
        FnSll  = 6'b000000,
        FnSrl  = 6'b000010,
        FnSra  = 6'b000011,
        FnJr   = 6'b001000,
        FnAddu = 6'b100001,
        FnSubu = 6'b100011,
        FnAnd  = 6'b100100,
        FnOr   = 6'b100101,
        FnXor  = 6'b100110,
        FnSlt  = 6'b101010,
        FnSltu = 6'b101011
    } func_t;

    localparam regAddr_t LinkReg = 5'd31;
    localparam word_t DefaultResetVector = 32'hBFC0_0000;

endpackage

`default_nettype wire

// ==== hw/mipsCpuBus.sv ====
`default_nettype none
`timescale 1ns/1ps

module mipsCpuBus import isaPkg::*, ctrlPkg::*; #(
    parameter word_t ResetVector = DefaultResetVector
) (
    input  wire logic  clk,
    input  wire logic  rst,
    output logic       active,
    output word_t      registerV0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  wire logic  waitrequest,
    output word_t      writedata,
    input  wire word_t readdata
);

    cpuState_t state;
    aluOp_t aluOp;
    wbSel_t wbSel;
    logic latchInstr;
    logic latchOperands;
    logic regWrite;
    logic pcAdvance;
    logic pcIsZero;
    logic useImm;
    logic isLoad;
    logic isStore;
    logic isBranchEq;
    logic isBranchNe;
    logic isJump;
    logic isJumpReg;
    logic writesReg;
    logic zero;
    logic branchTaken;
    logic [4:0] shamt;
    logic [25:0] jumpIndex;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t dest;
    word_t imm;
    word_t pc;
    word_t pcPlus4;
    word_t linkAddr;
    word_t rdDataA;
    word_t rdDataB;
    word_t opB;
    word_t result;
    word_t wrData;
    word_t target;
    word_t loadData;

    instrDecode decode0 (
        .clk(clk), .rst(rst), .latchInstr(latchInstr), .readdata(readdata),
        .aluOp(aluOp), .useImm(useImm), .zeroExtImm(),
        .isLoad(isLoad), .isStore(isStore), .isBranchEq(isBranchEq),
        .isBranchNe(isBranchNe), .isJump(isJump), .isJumpReg(isJumpReg),
        .writesReg(writesReg), .wbSel(wbSel), .rs(rs), .rt(rt), .dest(dest),
        .shamt(shamt), .imm(imm), .jumpIndex(jumpIndex)
    );

    cpuControl control0 (
        .clk(clk), .rst(rst), .waitrequest(waitrequest), .isLoad(isLoad),
        .isStore(isStore), .pcIsZero(pcIsZero), .state(state), .read(read),
        .write(write), .active(active), .latchInstr(latchInstr),
        .latchOperands(latchOperands), .regWrite(regWrite),
        .pcAdvance(pcAdvance), .writesReg(writesReg)
    );

    pcCounter #(.ResetVector(ResetVector)) pc0 (
        .clk(clk), .rst(rst), .pcAdvance(pcAdvance), .branchTaken(branchTaken),
        .target(target), .pc(pc), .linkAddr(linkAddr), .pcIsZero(pcIsZero)
    );

    regFile regs0 (
        .clk(clk), .rst(rst), .regWrite(regWrite), .wrAddr(dest),
        .rdAddrA(rs), .rdAddrB(rt), .wrData(wrData),
        .rdDataA(rdDataA), .rdDataB(rdDataB), .registerV0(registerV0)
    );

    alu alu0 (
        .clk(clk), .latchOperands(latchOperands), .op(aluOp), .opA(rdDataA),
        .opB(opB), .shamt(shamt), .result(result), .zero(zero)
    );

    assign opB = useImm ? imm : rdDataB;
    assign address = (state == Fetch) ? pc : result;
    assign writedata = rdDataB;

    // Load data is valid only in the completing Mem cycle
    always_ff @(posedge clk) begin
        if (state == Mem && isLoad && !waitrequest) begin
            loadData <= readdata;
        end
    end

    always_comb begin
        case (wbSel)
            MemData: wrData = loadData;
            LinkAddr: wrData = linkAddr;
            default: wrData = result;
        endcase
    end

    // Branch decision resolves in Exec
    assign branchTaken = state == Exec
        && ((isBranchEq && zero) || (isBranchNe && !zero) || isJump || isJumpReg);

    assign pcPlus4 = pc + 32'd4;
    assign target = isJumpReg ? result
        : isJump ? {pcPlus4[31:28], jumpIndex, 2'b00}
        : pcPlus4 + {imm[29:0], 2'b00};

endmodule

`default_nettype wire

// ==== hw/pcCounter.sv ====
`default_nettype none
`timescale 1ns/1ps

module pcCounter import isaPkg::*; #(
    parameter word_t ResetVector = DefaultResetVector
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  pcAdvance,
    input  wire logic  branchTaken,
    input  wire word_t target,
    output word_t      pc,
    output word_t      linkAddr,
    output logic       pcIsZero
);

    word_t savedTarget;
    logic pending;   // Branch resolved, delay slot still ahead
    logic inSlot;    // Delay slot running, redirect on next advance

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ResetVector;
            pending <= 1'b0;
            inSlot <= 1'b0;
        end else begin
            if (pcAdvance) begin
                pc <= inSlot ? savedTarget : pc + 32'd4;
                inSlot <= pending;
                pending <= 1'b0;
            end
            if (branchTaken) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (branchTaken) begin
            savedTarget <= target;
        end
    end

    assign linkAddr = pc + 32'd8;   // Skips the delay slot
    assign pcIsZero = pc == '0;

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`default_nettype none
`timescale 1ns/1ps

module regFile import isaPkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     regWrite,
    input  wire regAddr_t wrAddr,
    input  wire regAddr_t rdAddrA,
    input  wire regAddr_t rdAddrB,
    input  wire word_t    wrData,
    output word_t         rdDataA,
    output word_t         rdDataB,
    output word_t         registerV0
);

    word_t regs [NumRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && wrAddr != '0) begin
            regs[wrAddr] <= wrData;   // $zero stays zero
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];
    assign registerV0 = regs[2];

endmodule

`default_nettype wire

// ==== sources.f ====
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/instrDecode.sv
hw/cpuControl.sv
hw/pcCounter.sv
hw/regFile.sv
hw/alu.sv
hw/mipsCpuBus.sv
bench/mipsCpuBusSva_sva.sv
bench/mipsCpuBusTb.sv
